/* logic/cnu_pkg.sv */
// shared widths, limits and row result type for the check node unit and its testbench
package cnu_pkg;

  //--------------------------------------------------------------------
  // widths and limits
  //--------------------------------------------------------------------

  localparam int NODE_W  = 8;   // llr word width
  localparam int MAX_DEG = 16;  // largest row degree
  localparam int COL_W   = 4;   // column index width, covers MAX_DEG

  localparam logic [NODE_W-1:0] MAG_MASKED = '1;   // masked edge never wins a min
  localparam logic [NODE_W-1:0] CLIP_MAX   = 8'd127; // largest output magnitude

  //--------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------

  typedef logic signed [NODE_W-1:0] node_t;   // two's complement llr
  typedef logic        [NODE_W-1:0] mag_t;    // unsigned magnitude
  typedef logic        [COL_W-1:0]  col_t;
  typedef logic        [MAX_DEG-1:0] sign_vec_t; // one sign per column

  // one finished row, sorter -> fifo -> expander
  typedef struct packed {
    logic      prod_sign;  // xor of all edge signs, 1 = parity check failed
    mag_t      min1;       // smallest magnitude, normalized
    mag_t      min2;       // second smallest, normalized
    col_t      min1_col;   // column of min1
    col_t      deg_m1;     // row degree - 1
    sign_vec_t sign_vec;   // edge signs by column
  } row_result_t;

endpackage

/* logic/cnu_sort_engine.sv */
// serial min-sum sorter taking one v2c edge per beat and giving one normalized result per row
`timescale 1ns/10ps

module cnu_sort_engine #(
  parameter int NORM_FACTOR = 6  // scale = NORM_FACTOR/8 where 0 or 8 disables
) (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 norm_bypass,
  input  logic                 in_valid,
  input  logic                 in_sop,
  input  logic                 in_eop,
  input  logic                 in_mask,
  input  cnu_pkg::node_t       in_node,
  output logic                 in_ready,
  output logic                 res_valid,
  output cnu_pkg::row_result_t res_data,
  input  logic                 res_ready
);

  import cnu_pkg::*;

  localparam bit SCALE_EN = (NORM_FACTOR > 0) && (NORM_FACTOR < 8);

  logic      en;           // whole pipe advances
  logic      in_row;       // between sop and eop on the input side

  logic      s1_valid, s1_sop, s1_eop;
  logic      s1_sign;
  mag_t      s1_mag;
  col_t      s1_col, col_next;
  sign_vec_t s1_sign_vec, sign_vec_next;
  logic      edge_sign;

  logic      s2_done;
  logic      s2_sign;
  mag_t      s2_min1, s2_min2;
  col_t      s2_min1_col, s2_deg_m1;
  sign_vec_t s2_sign_vec;
  logic      check1, check2;

  // stall only when a finished row cannot leave stage 3
  assign en       = !(res_valid && !res_ready);
  assign in_ready = en;

  //--------------------------------------------------------------------
  // stage 1 sign / magnitude, column count and sign vector
  //--------------------------------------------------------------------

  assign edge_sign     = in_mask ? 1'b0 : in_node[NODE_W-1];
  assign col_next      = in_sop ? '0 : s1_col + 1'b1;
  assign sign_vec_next = (in_sop ? '0 : s1_sign_vec) | (sign_vec_t'(edge_sign) << col_next);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_valid <= 1'b0;
      in_row   <= 1'b0;
    end else if (en) begin
      s1_valid <= in_valid;
      if (in_valid) in_row <= !in_eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (en && in_valid) begin
      s1_sop      <= in_sop;
      s1_eop      <= in_eop;
      s1_sign     <= edge_sign;
      s1_mag      <= in_mask ? MAG_MASKED
                     : (in_node[NODE_W-1] ? mag_t'(-in_node) : mag_t'(in_node));  // -128 gives 128
      s1_col      <= col_next;
      s1_sign_vec <= sign_vec_next;
    end
  end

  //--------------------------------------------------------------------
  // stage 2 running two-min sort and parity
  //--------------------------------------------------------------------

  assign check1 = (s1_mag < s2_min1);  // strict so the earlier column keeps a tie
  assign check2 = (s1_mag < s2_min2);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) s2_done <= 1'b0;
    else if (en) s2_done <= s1_valid && s1_eop;
  end

  always_ff @(posedge iclk) begin
    if (en && s1_valid) begin
      s2_deg_m1   <= s1_col;
      s2_sign_vec <= s1_sign_vec;
      if (s1_sop) begin  // restart on first edge
        s2_sign     <= s1_sign;
        s2_min1     <= s1_mag;
        s2_min2     <= MAG_MASKED;
        s2_min1_col <= s1_col;
      end else begin
        s2_sign <= s2_sign ^ s1_sign;
        if (check1) begin
          s2_min1     <= s1_mag;
          s2_min1_col <= s1_col;
        end
        if (check2) s2_min2 <= check1 ? s2_min1 : s1_mag;  // old min1 slides down
      end
    end
  end

  //--------------------------------------------------------------------
  // stage 3 normalize and hold until the fifo takes it
  //--------------------------------------------------------------------

  // (m * NORM_FACTOR + 4) / 8 with truncation
  function automatic mag_t normalize(input mag_t m);
    logic [NODE_W+2:0] tmp;
    tmp = {3'b000, m} * (NODE_W+3)'(NORM_FACTOR) + (NODE_W+3)'(4);
    return tmp[NODE_W+2:3];
  endfunction

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) res_valid <= 1'b0;
    else if (en) res_valid <= s2_done;  // en means the old result is gone
  end

  always_ff @(posedge iclk) begin
    if (en && s2_done) begin
      res_data.prod_sign <= s2_sign;
      res_data.min1_col  <= s2_min1_col;
      res_data.deg_m1    <= s2_deg_m1;
      res_data.sign_vec  <= s2_sign_vec;
      if (SCALE_EN && !norm_bypass) begin
        res_data.min1 <= normalize(s2_min1);
        res_data.min2 <= normalize(s2_min2);
      end else begin
        res_data.min1 <= s2_min1;
        res_data.min2 <= s2_min2;
      end
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------

  // a stalled result stays put until the fifo takes it
  a_stall_hold : assert property (@(posedge iclk) disable iff (ireset)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_data)));

  // sop only after the previous eop and other beats only inside a row
  a_row_framing : assert property (@(posedge iclk) disable iff (ireset)
    (in_valid && in_ready) |-> (in_sop ? !in_row : in_row));

endmodule

/* logic/cnu_row_fifo.sv */
// synchronous fifo for row results between sorter and expander with a type parameter payload
`timescale 1ns/10ps

module cnu_row_fifo #(
  parameter int  DEPTH     = 4,            // power of two and at least 2
  parameter type payload_t = logic [7:0]
) (
  input  logic     iclk,
  input  logic     ireset,
  input  logic     wr_valid,
  input  payload_t wr_data,
  output logic     wr_ready,
  output logic     rd_valid,
  output payload_t rd_data,
  input  logic     rd_ready
);

  localparam int PTR_W = $clog2(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;   // wrap naturally since DEPTH is 2^n
  logic [PTR_W:0]   count;            // occupancy 0..DEPTH
  logic             push, pop;

  assign wr_ready = (count != (PTR_W+1)'(DEPTH));  // low while full
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  assign push = wr_valid && wr_ready;
  assign pop  = rd_valid && rd_ready;

  //--------------------------------------------------------------------
  // pointers and count
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or both on the same edge
      endcase
    end
  end

  // entry storage
  always_ff @(posedge iclk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------

  a_no_overflow : assert property (@(posedge iclk) disable iff (ireset)
    count <= (PTR_W+1)'(DEPTH));

  // pointers together and not full means empty, so nothing to read
  a_no_read_empty : assert property (@(posedge iclk) disable iff (ireset)
    ((wr_ptr == rd_ptr) && (count != (PTR_W+1)'(DEPTH))) |-> !rd_valid);

endmodule

/* logic/cnu_msg_expander.sv */
// turns each row result back into per-edge c2v messages with framing and parity fail flag
`timescale 1ns/10ps

module cnu_msg_expander (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 row_valid,
  input  cnu_pkg::row_result_t row_data,
  output logic                 row_ready,
  output logic                 out_valid,
  output cnu_pkg::node_t       out_node,
  output logic                 out_sop,
  output logic                 out_eop,
  output logic                 out_row_fail,
  input  logic                 out_ready
);

  import cnu_pkg::*;

  logic        busy;      // a row is loaded
  row_result_t cur;       // row being expanded
  col_t        col;       // current column
  logic        last;      // col at deg_m1
  logic        out_fire;
  mag_t        mag;
  node_t       clip;
  logic        neg;

  assign last     = (col == cur.deg_m1);
  assign out_fire = out_valid && out_ready;

  // take next row when idle or as the current one finishes, rows stay back to back
  assign row_ready = !busy || (out_fire && last);

  //--------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy <= 1'b0;
      col  <= '0;
    end else if (row_valid && row_ready) begin
      busy <= 1'b1;
      col  <= '0;
    end else if (out_fire) begin
      if (last) busy <= 1'b0;
      else      col  <= col + 1'b1;
    end
  end

  always_ff @(posedge iclk) begin
    if (row_valid && row_ready) cur <= row_data;
  end

  //--------------------------------------------------------------------
  // message build
  //--------------------------------------------------------------------

  assign mag  = (col == cur.min1_col) ? cur.min2 : cur.min1;  // own edge excluded
  assign clip = (mag > CLIP_MAX) ? node_t'(CLIP_MAX) : node_t'(mag);
  assign neg  = cur.prod_sign ^ cur.sign_vec[col];            // drop own sign from parity

  assign out_valid    = busy;
  assign out_node     = neg ? -clip : clip;
  assign out_sop      = (col == '0);
  assign out_eop      = last;
  assign out_row_fail = cur.prod_sign;  // odd parity = check failed

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------

  // stalled message held unchanged
  a_out_hold : assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_node) && $stable(out_eop)));

endmodule

/* logic/cnu_top.sv */
// check node unit top, sorter -> row fifo -> message expander with valid/ready between them
`timescale 1ns/10ps

module cnu_top #(
  parameter int NORM_FACTOR = 6,  // min scaling, 6/8
  parameter int DEPTH       = 4   // rows buffered
) (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           norm_bypass,
  // v2c input stream
  input  logic           in_valid,
  input  logic           in_sop,
  input  logic           in_eop,
  input  logic           in_mask,
  input  cnu_pkg::node_t in_node,
  output logic           in_ready,
  // c2v output stream
  output logic           out_valid,
  output cnu_pkg::node_t out_node,
  output logic           out_sop,
  output logic           out_eop,
  output logic           out_row_fail,
  input  logic           out_ready
);

  import cnu_pkg::*;

  //--------------------------------------------------------------------
  // row result links
  //--------------------------------------------------------------------

  logic        res_valid, res_ready;  // sorter -> fifo
  row_result_t res_data;
  logic        row_valid, row_ready;  // fifo -> expander
  row_result_t row_data;

  cnu_sort_engine #(
    .NORM_FACTOR (NORM_FACTOR)
  ) sort_i (
    .iclk        (iclk),
    .ireset      (ireset),
    .norm_bypass (norm_bypass),
    .in_valid    (in_valid),
    .in_sop      (in_sop),
    .in_eop      (in_eop),
    .in_mask     (in_mask),
    .in_node     (in_node),
    .in_ready    (in_ready),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_ready   (res_ready)
  );

  cnu_row_fifo #(
    .DEPTH     (DEPTH),
    .payload_t (row_result_t)
  ) fifo_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .wr_valid (res_valid),
    .wr_data  (res_data),
    .wr_ready (res_ready),
    .rd_valid (row_valid),
    .rd_data  (row_data),
    .rd_ready (row_ready)
  );

  cnu_msg_expander expand_i (
    .iclk         (iclk),
    .ireset       (ireset),
    .row_valid    (row_valid),
    .row_data     (row_data),
    .row_ready    (row_ready),
    .out_valid    (out_valid),
    .out_node     (out_node),
    .out_sop      (out_sop),
    .out_eop      (out_eop),
    .out_row_fail (out_row_fail),
    .out_ready    (out_ready)
  );

endmodule

/* test/cnu_tb.sv */
// testbench for the check node unit, random rows checked against a reference queue by assertions
`timescale 1ns/10ps

module cnu_tb;

  import cnu_pkg::*;

  localparam int NORM   = 6;     // scale 6/8, same as dut_i
  localparam int EXP_AW = 11;    // expected store holds 2^11 messages
  localparam int LIMIT  = 2000;  // cycles allowed per wait loop

  logic  iclk = 1'b0;
  logic  ireset, norm_bypass;
  logic  in_valid, in_sop, in_eop, in_mask, in_ready;
  node_t in_node;
  logic  out_valid, out_sop, out_eop, out_row_fail, out_ready;
  node_t out_node;

  int    seed;
  int    ready_pct;      // out_ready duty in percent
  int    stall_cycles;   // cycles with in_ready low
  int    wr_idx, rd_idx; // expected store pointers, free running

  // expected c2v messages, circular
  node_t exp_node [2**EXP_AW];
  logic  exp_sop  [2**EXP_AW];
  logic  exp_eop  [2**EXP_AW];
  logic  exp_fail [2**EXP_AW];

  logic  fire, pending;
  node_t head_node;
  logic  head_sop, head_eop, head_fail;

  cnu_top #(.NORM_FACTOR(NORM), .DEPTH(4)) dut_i (
    .iclk(iclk), .ireset(ireset), .norm_bypass(norm_bypass),
    .in_valid(in_valid), .in_sop(in_sop), .in_eop(in_eop), .in_mask(in_mask),
    .in_node(in_node), .in_ready(in_ready),
    .out_valid(out_valid), .out_node(out_node), .out_sop(out_sop), .out_eop(out_eop),
    .out_row_fail(out_row_fail), .out_ready(out_ready)
  );

  always #5 iclk = ~iclk;  // 10 ns period

  //----------------------------------------------------------------------
  // helpers
  //----------------------------------------------------------------------

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
    stop_run($sformatf("error %s expected 0x%h got 0x%h", name, exp, act));
  endtask

  function automatic int pick(input int lo, input int hi);  // uniform lo..hi
    return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  function automatic int scale(input int m, input bit bypass);
    if (bypass) return m;
    return (m * NORM + 4) / 8;  // truncating
  endfunction

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!in_ready) begin  // in_ready is register driven, stable here
      @(negedge iclk);
      waited++;
      if (waited > LIMIT) stop_run("input beat not accepted, in_ready stayed low");
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (rd_idx != wr_idx) begin
      @(negedge iclk);
      waited++;
      if (waited > LIMIT * 4) stop_run("expected output messages not received before timeout");
    end
    repeat (4) @(negedge iclk);  // stray beats would hit a_expected
  endtask

  // one row: reference messages into the store, then the beats back to back
  task automatic send_row(input bit bypass);
    node_t v   [MAX_DEG];
    logic  m   [MAX_DEG];
    int    mag [MAX_DEG];
    int    deg, kind, c1, m2, n1, n2, o, i;
    logic  par;
    deg  = pick(2, MAX_DEG);
    kind = pick(0, 2);  // 0 wide random, 1 small values for ties, 2 many -128
    par  = 1'b0;
    for (i = 0; i < deg; i++) begin
      case (kind)
        1:       v[i] = node_t'(pick(-3, 3));
        2:       v[i] = pick(0, 1) ? node_t'(-128) : node_t'($random(seed));
        default: v[i] = node_t'($random(seed));
      endcase
      m[i]   = (pick(0, 7) == 0);  // about one edge in eight masked
      mag[i] = m[i] ? 255 : ((v[i] < 0) ? -int'(v[i]) : int'(v[i]));
      if (!m[i]) par ^= v[i][NODE_W-1];
    end
    c1 = 0;  // first smallest wins a tie
    for (i = 1; i < deg; i++) begin
      if (mag[i] < mag[c1]) c1 = i;
    end
    m2 = 256;  // smallest over the other columns
    for (i = 0; i < deg; i++) begin
      if (i != c1 && mag[i] < m2) m2 = mag[i];
    end
    n1 = scale(mag[c1], bypass);
    n2 = scale(m2, bypass);
    for (i = 0; i < deg; i++) begin
      o = (i == c1) ? n2 : n1;
      if (o > 127) o = 127;
      if (par ^ (m[i] ? 1'b0 : v[i][NODE_W-1])) o = -o;  // row parity without own sign
      exp_node[wr_idx[EXP_AW-1:0]] = node_t'(o);
      exp_sop[wr_idx[EXP_AW-1:0]]  = (i == 0);
      exp_eop[wr_idx[EXP_AW-1:0]]  = (i == deg - 1);
      exp_fail[wr_idx[EXP_AW-1:0]] = par;
      wr_idx++;
    end
    for (i = 0; i < deg; i++) begin
      in_valid = 1'b1;
      in_sop   = (i == 0);
      in_eop   = (i == deg - 1);
      in_mask  = m[i];
      in_node  = v[i];
      wait_ready();
      @(negedge iclk);  // taken on the edge just passed
    end
    in_valid = 1'b0;
  endtask

  task automatic drive_out_ready();
    forever begin
      @(negedge iclk);
      out_ready = (pick(0, 99) < ready_pct);
    end
  endtask

  //----------------------------------------------------------------------
  // checks on every transferred output beat
  //----------------------------------------------------------------------

  assign fire      = out_valid && out_ready;
  assign pending   = (rd_idx != wr_idx);
  assign head_node = exp_node[rd_idx[EXP_AW-1:0]];
  assign head_sop  = exp_sop[rd_idx[EXP_AW-1:0]];
  assign head_eop  = exp_eop[rd_idx[EXP_AW-1:0]];
  assign head_fail = exp_fail[rd_idx[EXP_AW-1:0]];

  always @(posedge iclk or posedge ireset) begin
    if (ireset) rd_idx <= 0;
    else if (fire) rd_idx <= rd_idx + 1;  // pop head
  end

  always @(negedge iclk) begin
    if (ireset) stall_cycles <= 0;
    else if (!in_ready) stall_cycles <= stall_cycles + 1;
  end

  a_expected : assert property (@(posedge iclk) disable iff (ireset) fire |-> pending)
    else stop_run("output message received while no message was expected");
  a_node : assert property (@(posedge iclk) disable iff (ireset)
    (fire && pending) |-> (out_node == head_node))
    else report_mismatch("out_node", $sampled(head_node), $sampled(out_node));
  a_sop : assert property (@(posedge iclk) disable iff (ireset)
    (fire && pending) |-> (out_sop == head_sop))
    else report_mismatch("out_sop", {7'd0, $sampled(head_sop)}, {7'd0, $sampled(out_sop)});
  a_eop : assert property (@(posedge iclk) disable iff (ireset)
    (fire && pending) |-> (out_eop == head_eop))
    else report_mismatch("out_eop", {7'd0, $sampled(head_eop)}, {7'd0, $sampled(out_eop)});
  a_fail : assert property (@(posedge iclk) disable iff (ireset)
    (fire && pending) |-> (out_row_fail == head_fail))
    else report_mismatch("out_row_fail", {7'd0, $sampled(head_fail)},
                         {7'd0, $sampled(out_row_fail)});

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------

  initial begin
    seed        = 32'h98db_ebe3;
    ireset      = 1'b1;
    norm_bypass = 1'b0;
    in_valid    = 1'b0;
    in_sop      = 1'b0;
    in_eop      = 1'b0;
    in_mask     = 1'b0;
    in_node     = '0;
    out_ready   = 1'b0;
    wr_idx      = 0;
    ready_pct   = 100;
    fork
      drive_out_ready();
    join_none
    repeat (8) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    repeat (20) send_row(1'b0);  // full rate output
    ready_pct = 30;              // heavy back-pressure, fifo fills
    repeat (40) send_row(1'b0);
    drain_outputs();
    norm_bypass = 1'b1;          // switched only while idle
    ready_pct   = 60;
    repeat (25) send_row(1'b1);
    drain_outputs();
    if (stall_cycles == 0) begin
      stop_run("in_ready never went low under output back-pressure");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* list.f */
logic/cnu_pkg.sv
logic/cnu_sort_engine.sv
logic/cnu_row_fifo.sv
logic/cnu_msg_expander.sv
logic/cnu_top.sv
test/cnu_tb.sv

/* run.sh */
#!/bin/sh
# build the check node unit testbench with Verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module cnu_tb -f list.f -o cnu_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cnu_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log

grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL: run did not finish"; exit 1; }
